//--- project.f
rtl/approxMulPkg.sv
rtl/axiLiteIf.sv
rtl/partialProductTree.sv
rtl/carrySaveCompressor.sv
rtl/configurableFinalAdder.sv
rtl/approxMultiplier.sv
rtl/mulRegBank.sv
rtl/approxMulTop.sv
dv/approxMulBus_props.sv
dv/approxMulTb.sv

//--- dv/approxMulTb.sv
`timescale 1ns/1ps
`default_nettype none

module approxMulTb import approxMulPkg::*;
();

    logic CLK;
    logic rst;
    logic [AddrWidth-1:0] awaddr;
    logic awvalid;
    logic awready;
    wordT wdata;
    logic wvalid;
    logic wready;
    axiRespE bresp;
    logic bvalid;
    logic bready;
    logic [AddrWidth-1:0] araddr;
    logic arvalid;
    logic arready;
    wordT rdata;
    axiRespE rresp;
    logic rvalid;
    logic rready;

    logic [31:0] lfsr = 32'h1be6;
    int timeoutCycles = 100;

    approxMulTop uut (
        .CLK(CLK), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    always #50 CLK = ~CLK;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(negedge CLK)
    begin
        if (uut.regBank.busProps.violations != 0)
            abortRun("A bus assertion failed.");
    end

    // Fibonacci LFSR, taps 32, 22, 2 and 1.
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    //##################################################
    // Reference model
    function automatic void pairRows(input logic [14:0] low, input logic [14:0] high,
                                     input int width, input int shift,
                                     output logic [14:0] p, output logic [14:0] q);
        logic lo;
        logic hi;
        for (int i = 0; i < 15; i++)
        begin
            lo = (i < width) ? low[i] : 1'b0;
            hi = (i >= shift) ? high[i-shift] : 1'b0;
            p[i] = lo | hi;
            q[i] = lo & hi;
        end
    endfunction

    function automatic productT modelProduct(input operandT a, input operandT b,
                                             input errCtrlT ec);
        logic [14:0] pp [8];
        logic [14:0] row [4];
        logic [14:0] p5, p6, p7, q7, q, v1, v2, s, c;
        logic x, y, z, carry, exactBit;
        productT prod;
        for (int i = 0; i < 8; i++)
            pp[i] = b[i] ? 15'(a) : 15'd0;
        v1 = '0;
        v2 = '0;
        for (int i = 0; i < 4; i++)
        begin
            pairRows(pp[2*i], pp[2*i+1], 8, 1, row[i], q);
            v1 = v1 | (q << (2 * i));
        end
        pairRows(row[0], row[1], 9, 2, p5, q);
        v2 = v2 | q;
        pairRows(row[2], row[3], 9, 2, p6, q);
        v2 = v2 | (q << 4);
        pairRows(p5, p6, 11, 4, p7, q7);
        s = '0;
        c = '0;
        for (int col = 0; col < 15; col++)
        begin
            x = p7[col];
            y = 1'b0;
            z = 1'b0;
            if (col == 1 || col == 13)
                y = v1[col];
            else if ((col >= 2 && col <= 3) || (col >= 11 && col <= 12))
            begin
                y = v1[col];
                z = v2[col];
            end
            else if (col >= 4 && col <= 10)
            begin
                y = q7[col];
                z = v1[col] | v2[col];
            end
            s[col] = x ^ y ^ z;
            if (col < 14)
                c[col+1] = (x & y) | (z & (x ^ y));
        end
        prod = '0;
        prod[1:0] = s[1:0];
        prod[4:2] = s[4:2] | c[4:2];
        carry = 1'b0;
        for (int k = 5; k < 15; k++)
        begin
            x = s[k];
            y = c[k];
            exactBit = (k >= 12) ? 1'b1 : ec[k-5];
            if (exactBit)
            begin
                prod[k] = x ^ y ^ carry;
                carry = (x & y) | (carry & (x ^ y));
            end
            else
            begin
                prod[k] = (x ^ y) | carry;  // Approximate cell.
                carry = x & (y | carry);
            end
        end
        prod[15] = carry;
        return prod;
    endfunction

    //##################################################
    // Compare tasks
    task automatic checkProduct(input productT actual, input productT expected, input string what);
        if (actual !== expected)
            abortRun($sformatf("FAIL at %0t: %s: product %h, expected %h",
                               $time, what, actual, expected));
    endtask

    task automatic checkResp(input axiRespE actual, input axiRespE expected, input string what);
        if (actual !== expected)
            abortRun($sformatf("FAIL at %0t: %s: response %b, expected %b",
                               $time, what, actual, expected));
    endtask

    task automatic checkWord(input wordT actual, input wordT expected, input string what);
        if (actual !== expected)
            abortRun($sformatf("FAIL at %0t: %s: word %h, expected %h",
                               $time, what, actual, expected));
    endtask

    //##################################################
    // Bus tasks, entered and left on a falling edge
    task automatic axiWrite(input logic [AddrWidth-1:0] addr, input wordT data,
                            input int holdCycles, output axiRespE resp);
        int waitCount;
        logic accepted;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        accepted = 1'b0;
        waitCount = 0;
        while (!accepted && waitCount < timeoutCycles)
        begin
            #5 accepted = awready && wready;  // Ready is combinational, let it settle.
            @(negedge CLK);
            waitCount++;
        end
        if (!accepted)
            abortRun("Timed out waiting for the write to be accepted.");
        awvalid = 1'b0;
        wvalid = 1'b0;
        waitCount = 0;
        while (!bvalid && waitCount < timeoutCycles)
        begin
            @(negedge CLK);
            waitCount++;
        end
        if (!bvalid)
            abortRun("Timed out waiting for the write response.");
        resp = bresp;
        repeat (holdCycles)
        begin
            @(negedge CLK);
            if (!bvalid)
                abortRun("The write response went away while bready was low.");
            checkResp(bresp, resp, "bresp while bready low");
        end
        bready = 1'b1;
        @(negedge CLK);
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [AddrWidth-1:0] addr, input int holdCycles,
                           output wordT data, output axiRespE resp);
        int waitCount;
        logic accepted;
        araddr = addr;
        arvalid = 1'b1;
        accepted = 1'b0;
        waitCount = 0;
        while (!accepted && waitCount < timeoutCycles)
        begin
            #5 accepted = arready;
            @(negedge CLK);
            waitCount++;
        end
        if (!accepted)
            abortRun("Timed out waiting for the read address to be accepted.");
        arvalid = 1'b0;
        waitCount = 0;
        while (!rvalid && waitCount < timeoutCycles)
        begin
            @(negedge CLK);
            waitCount++;
        end
        if (!rvalid)
            abortRun("Timed out waiting for the read data.");
        data = rdata;
        resp = rresp;
        repeat (holdCycles)
        begin
            @(negedge CLK);
            if (!rvalid)
                abortRun("The read data went away while rready was low.");
            checkWord(rdata, data, "rdata while rready low");
            checkResp(rresp, resp, "rresp while rready low");
        end
        rready = 1'b1;
        @(negedge CLK);
        rready = 1'b0;
    endtask

    task automatic expectRead(input logic [AddrWidth-1:0] addr, input wordT expected,
                              input axiRespE expectedResp, input string what);
        wordT data;
        axiRespE resp;
        axiRead(addr, randomBits(3), data, resp);
        checkResp(resp, expectedResp, what);
        checkWord(data, expected, what);
    endtask

    // Reads the status bit straight after an operand write and polls until the product is back.
    task automatic awaitResult(output productT got);
        wordT data;
        axiRespE resp;
        int polls;
        axiRead(regStatus, 0, data, resp);
        checkWord(data, 32'd0, "status right after operand write");
        polls = 0;
        while (data[0] !== 1'b1 && polls < timeoutCycles)
        begin
            axiRead(regStatus, randomBits(2), data, resp);
            polls++;
        end
        if (data[0] !== 1'b1)
            abortRun("Timed out polling the status register for a new result.");
        axiRead(regResult, randomBits(3), data, resp);
        checkResp(resp, respOkay, "result read");
        got = data[ProductWidth-1:0];
    endtask

    // One full product, from the control write to the result read.
    task automatic runProduct(input operandT a, input operandT b, input errCtrlT ec,
                              output productT got);
        axiRespE resp;
        axiWrite(regErrCtrl, wordT'(ec), randomBits(3), resp);
        checkResp(resp, respOkay, "control write");
        axiWrite(regOperands, wordT'({b, a}), 0, resp);
        checkResp(resp, respOkay, "operand write");
        awaitResult(got);
        checkProduct(got, modelProduct(a, b, ec),
                     $sformatf("a=%h b=%h ctrl=%h", a, b, ec));
    endtask

    initial
    begin
        wordT word;
        axiRespE resp;
        productT got;
        errCtrlT ec;
        operandT a;
        operandT b;
        CLK = 1'b0;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (8) @(negedge CLK);
        rst = 1'b0;

        // Control register keeps only its low seven bits.
        word = randomBits(32);
        axiWrite(regErrCtrl, word, randomBits(3), resp);
        checkResp(resp, respOkay, "control write");
        expectRead(regErrCtrl, wordT'(word[6:0]), respOkay, "control readback");

        for (int i = 0; i < 200; i++)
        begin
            if (i == 0)
                ec = '0;
            else if (i == 1)
                ec = '1;
            else
                ec = randomBits(7);
            runProduct(randomBits(8), randomBits(8), ec, got);
        end

        //##################################################
        // Control word rewritten while its product is in flight
        for (int i = 0; i < 8; i++)
        begin
            a = randomBits(8);
            b = randomBits(8);
            ec = randomBits(7);
            axiWrite(regErrCtrl, wordT'(ec), 0, resp);
            checkResp(resp, respOkay, "control write");
            axiWrite(regOperands, wordT'({b, a}), 0, resp);
            checkResp(resp, respOkay, "operand write");
            axiWrite(regErrCtrl, wordT'(~ec), 0, resp);
            checkResp(resp, respOkay, "control write in flight");
            awaitResult(got);
            checkProduct(got, modelProduct(a, b, ec), "control word of the launch");
        end

        //##################################################
        // Second launch while the first product is still in the pipeline
        for (int i = 0; i < 8; i++)
        begin
            a = randomBits(8);
            b = randomBits(8);
            ec = randomBits(7);
            axiWrite(regErrCtrl, wordT'(ec), 0, resp);
            checkResp(resp, respOkay, "control write");
            // One held cycle lands the second launch as the first product comes out.
            axiWrite(regOperands, randomBits(16), 1, resp);
            checkResp(resp, respOkay, "first operand write");
            axiWrite(regOperands, wordT'({b, a}), 0, resp);
            checkResp(resp, respOkay, "second operand write");
            awaitResult(got);
            checkProduct(got, modelProduct(a, b, ec), "newest of two launches");
        end

        //##################################################
        // Read-only and unmapped offsets
        runProduct(8'ha5, 8'h3c, 7'h55, got);
        axiWrite(regResult, 32'hffff_ffff, randomBits(3), resp);
        checkResp(resp, respSlvErr, "write to result");
        axiWrite(regStatus, 32'hffff_ffff, randomBits(3), resp);
        checkResp(resp, respSlvErr, "write to status");
        axiWrite(4'h6, 32'hffff_ffff, randomBits(3), resp);
        checkResp(resp, respSlvErr, "write to unmapped offset");
        expectRead(regErrCtrl, 32'h55, respOkay, "control after bad writes");
        expectRead(regOperands, 32'h3ca5, respOkay, "operands after bad writes");
        expectRead(regResult, wordT'(modelProduct(8'ha5, 8'h3c, 7'h55)), respOkay,
                   "result after bad writes");
        expectRead(regStatus, 32'h1, respOkay, "status after bad writes");
        expectRead(4'h2, 32'h0, respSlvErr, "read of unmapped offset");

        for (int i = 0; i < 4; i++)
        begin
            ec = randomBits(7);
            runProduct(8'h00, randomBits(8), ec, got);
            checkProduct(got, '0, "zero first operand");
            runProduct(randomBits(8), 8'h00, ec, got);
            checkProduct(got, '0, "zero second operand");
        end

        if (uut.regBank.busProps.violations != 0)
        begin
            $display("FAIL at %0t: %0d bus assertion failures", $time,
                     uut.regBank.busProps.violations);
            $display("Simulation failed");
            $fatal(1);
        end
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/approxMulBus_props.sv
`timescale 1ns/1ps
`default_nettype none

module approxMulBus_props import approxMulPkg::*;
(
    input logic CLK,
    input logic rst,
    input logic awvalid,
    input logic awready,
    input logic [AddrWidth-1:0] awaddr,
    input logic wvalid,
    input logic wready,
    input wordT wdata,
    input logic bvalid,
    input logic bready,
    input axiRespE bresp,
    input logic rvalid,
    input logic rready,
    input wordT rdata,
    input axiRespE rresp,
    input logic start,
    input logic productValid,
    input logic resultValid
);

    int violations = 0;  // Failed assertions so far.

    //##################################################
    // Handshake rules
    awHeld: assert property (@(posedge CLK) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else
        begin
            violations++;
            $error("Write address changed before it was accepted.");
        end

    wHeld: assert property (@(posedge CLK) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else
        begin
            violations++;
            $error("Write data changed before it was accepted.");
        end

    bHeld: assert property (@(posedge CLK) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else
        begin
            violations++;
            $error("Write response dropped before bready.");
        end

    rHeld: assert property (@(posedge CLK) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else
        begin
            violations++;
            $error("Read response dropped before rready.");
        end

    //##################################################
    // Status bit against launches
    launchWins: assert property (@(posedge CLK) disable iff (rst)
        start && productValid |=> !resultValid)
        else
        begin
            violations++;
            $error("An older product raised the status bit.");
        end

endmodule

bind mulRegBank approxMulBus_props busProps (
    .CLK(CLK), .rst(rst),
    .awvalid(bus.awvalid), .awready(bus.awready), .awaddr(bus.awaddr),
    .wvalid(bus.wvalid), .wready(bus.wready), .wdata(bus.wdata),
    .bvalid(bus.bvalid), .bready(bus.bready), .bresp(bus.bresp),
    .rvalid(bus.rvalid), .rready(bus.rready), .rdata(bus.rdata), .rresp(bus.rresp),
    .start(start), .productValid(productValid), .resultValid(resultValid)
);

`default_nettype wire

//--- rtl/approxMulTop.sv
`timescale 1ns/1ps
`default_nettype none

module approxMulTop import approxMulPkg::*;
(
    input logic CLK,
    input logic rst,
    input logic [AddrWidth-1:0] awaddr,
    input logic awvalid,
    output logic awready,
    input wordT wdata,
    input logic wvalid,
    output logic wready,
    output axiRespE bresp,
    output logic bvalid,
    input logic bready,
    input logic [AddrWidth-1:0] araddr,
    input logic arvalid,
    output logic arready,
    output wordT rdata,
    output axiRespE rresp,
    output logic rvalid,
    input logic rready
);

    axiLiteIf bus ();

    logic start;
    operandT opA;
    operandT opB;
    errCtrlT errCtrl;
    productT product;
    logic productValid;

    // Master side of the bus comes from the pins.
    assign bus.awaddr = awaddr;
    assign bus.awvalid = awvalid;
    assign bus.wdata = wdata;
    assign bus.wvalid = wvalid;
    assign bus.bready = bready;
    assign bus.araddr = araddr;
    assign bus.arvalid = arvalid;
    assign bus.rready = rready;

    assign awready = bus.awready;
    assign wready = bus.wready;
    assign bresp = bus.bresp;
    assign bvalid = bus.bvalid;
    assign arready = bus.arready;
    assign rdata = bus.rdata;
    assign rresp = bus.rresp;
    assign rvalid = bus.rvalid;

    mulRegBank regBank (
        .CLK(CLK), .rst(rst), .bus(bus.slave),
        .product(product), .productValid(productValid),
        .start(start), .opA(opA), .opB(opB), .errCtrl(errCtrl)
    );

    approxMultiplier multiplier (
        .CLK(CLK), .rst(rst), .start(start),
        .opA(opA), .opB(opB), .errCtrl(errCtrl),
        .product(product), .productValid(productValid)
    );

endmodule

`default_nettype wire

//--- rtl/mulRegBank.sv
`timescale 1ns/1ps
`default_nettype none

module mulRegBank import approxMulPkg::*;
(
    input logic CLK,
    input logic rst,
    axiLiteIf.slave bus,
    input productT product,
    input logic productValid,
    output logic start,
    output operandT opA,
    output operandT opB,
    output errCtrlT errCtrl
);

    wrStateE wrState;
    rdStateE rdState;
    productT result;
    logic resultValid;
    logic [1:0] pending;  // Products launched and not yet back.
    logic wrAccept;
    logic rdAccept;
    logic opWrite;

    assign wrAccept = (wrState == wrIdle) && bus.awvalid && bus.wvalid;
    assign bus.awready = wrAccept;
    assign bus.wready = wrAccept;
    assign bus.bvalid = (wrState == wrResp);
    assign opWrite = wrAccept && (bus.awaddr == regOperands);

    assign bus.arready = (rdState == rdIdle);
    assign rdAccept = bus.arvalid && bus.arready;
    assign bus.rvalid = (rdState == rdData);

    //##################################################
    // Write channel
    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            wrState <= wrIdle;
            errCtrl <= '0;
            opA <= '0;
            opB <= '0;
        end
        else if (wrAccept)
        begin
            wrState <= wrResp;
            case (bus.awaddr)
                regErrCtrl:
                begin
                    errCtrl <= bus.wdata[ErrCtrlWidth-1:0];
                    bus.bresp <= respOkay;
                end
                regOperands:
                begin
                    opA <= bus.wdata[OperandWidth-1:0];
                    opB <= bus.wdata[2*OperandWidth-1:OperandWidth];
                    bus.bresp <= respOkay;
                end
                default: bus.bresp <= respSlvErr;  // Read-only or unmapped.
            endcase
        end
        else if (wrState == wrResp && bus.bready)
            wrState <= wrIdle;
    end

    // Launch one cycle after the write, once the operand registers hold the new pair.
    always_ff @(posedge CLK)
    begin
        if (rst)
            start <= 1'b0;
        else
            start <= opWrite;
    end

    //##################################################
    // Result capture
    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            result <= '0;
            resultValid <= 1'b0;
            pending <= '0;
        end
        else
        begin
            if (productValid)
                result <= product;
            if (opWrite && !productValid)
                pending <= pending + 2'd1;
            else if (productValid && !opWrite)
                pending <= pending - 2'd1;
            // Only the newest launch may raise the status bit.
            if (opWrite)
                resultValid <= 1'b0;
            else if (productValid && pending == 2'd1)
                resultValid <= 1'b1;
        end
    end

    //##################################################
    // Read channel
    always_ff @(posedge CLK)
    begin
        if (rst)
            rdState <= rdIdle;
        else if (rdAccept)
        begin
            rdState <= rdData;
            bus.rresp <= respOkay;
            case (bus.araddr)
                regErrCtrl: bus.rdata <= wordT'(errCtrl);
                regOperands: bus.rdata <= wordT'({opB, opA});
                regResult: bus.rdata <= wordT'(result);
                regStatus: bus.rdata <= wordT'(resultValid);
                default:
                begin
                    bus.rdata <= '0;
                    bus.rresp <= respSlvErr;
                end
            endcase
        end
        else if (rdState == rdData && bus.rready)
            rdState <= rdIdle;
    end

endmodule

`default_nettype wire

//--- rtl/approxMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module approxMultiplier import approxMulPkg::*;
(
    input logic CLK,
    input logic rst,
    input logic start,
    input operandT opA,
    input operandT opB,
    input errCtrlT errCtrl,
    output productT product,
    output logic productValid
);

    rowT p5, p6, p5Q, p6Q;
    vecT v1, v2, v1Q, v2Q;
    vecT sumVec, carryVec, sumQ, carryQ;
    errCtrlT errCtrlS2, errCtrlS3;
    logic validS2, validS3;
    productT productNext;

    //##################################################
    // Stage 1
    partialProductTree tree (.opA(opA), .opB(opB), .p5(p5), .p6(p6), .v1(v1), .v2(v2));

    always_ff @(posedge CLK)
    begin
        p5Q <= p5;
        p6Q <= p6;
        v1Q <= v1;
        v2Q <= v2;
        errCtrlS2 <= errCtrl;  // The control word follows its operands.
    end

    //##################################################
    // Stage 2
    carrySaveCompressor compressor (
        .p5(p5Q), .p6(p6Q), .v1(v1Q), .v2(v2Q),
        .sumVec(sumVec), .carryVec(carryVec)
    );

    always_ff @(posedge CLK)
    begin
        sumQ <= sumVec;
        carryQ <= carryVec;
        errCtrlS3 <= errCtrlS2;
    end

    //##################################################
    // Stage 3
    configurableFinalAdder finalAdder (
        .errCtrl(errCtrlS3), .sumVec(sumQ), .carryVec(carryQ), .product(productNext)
    );

    always_ff @(posedge CLK)
        product <= productNext;

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            validS2 <= 1'b0;
            validS3 <= 1'b0;
            productValid <= 1'b0;
        end
        else
        begin
            validS2 <= start;
            validS3 <= validS2;
            productValid <= validS3;
        end
    end

endmodule

`default_nettype wire

//--- rtl/configurableFinalAdder.sv
`timescale 1ns/1ps
`default_nettype none

module configurableFinalAdder import approxMulPkg::*;
(
    input errCtrlT errCtrl,
    input vecT sumVec,
    input vecT carryVec,
    output productT product
);

    logic [9:0] exact;  // One entry per ripple bit from column 5 up.

    assign exact = {3'b111, errCtrl};

    always_comb
    begin
        logic a;
        logic b;
        logic cin;
        product = '0;
        product[1:0] = sumVec[1:0];
        product[4:2] = sumVec[4:2] | carryVec[4:2];  // Carries are dropped in the low columns.
        cin = 1'b0;
        for (int k = 5; k < VecWidth; k++)
        begin
            a = sumVec[k];
            b = carryVec[k];
            // With exact low the sum saturates to OR and the carry ignores b AND cin.
            product[k] = ~(exact[k-5] & (a ^ b) & cin) & ((a ^ b) | cin);
            cin = (exact[k-5] & b & cin) | ((b | cin) & a);
        end
        product[ProductWidth-1] = cin;
    end

endmodule

`default_nettype wire

//--- rtl/carrySaveCompressor.sv
`timescale 1ns/1ps
`default_nettype none

module carrySaveCompressor import approxMulPkg::*;
(
    input rowT p5,
    input rowT p6,
    input vecT v1,
    input vecT v2,
    output vecT sumVec,
    output vecT carryVec
);

    vecT p7;
    vecT q7;

    always_comb
    begin
        icacPair(vecT'(p5), vecT'(p6), OperandWidth + 3, 4, p7, q7);
    end

    // One adder per column. A half adder is a full adder with cin tied low,
    // and the two edge columns pass P7 straight through.
    always_comb
    begin
        logic a;
        logic b;
        logic cin;
        sumVec = '0;
        carryVec = '0;
        for (int c = 0; c < VecWidth; c++)
        begin
            a = p7[c];
            b = 1'b0;
            cin = 1'b0;
            if (c == 1 || c == 13)
                b = v1[c];
            else if ((c >= 2 && c <= 3) || (c >= 11 && c <= 12))
            begin
                b = v1[c];
                cin = v2[c];
            end
            else if (c >= 4 && c <= 10)
            begin
                b = q7[c];
                cin = v1[c] | v2[c];  // Residues overlap here, so they are merged.
            end
            sumVec[c] = a ^ b ^ cin;
            if (c < VecWidth - 1)
                carryVec[c+1] = (a & b) | (a & cin) | (b & cin);
        end
    end

endmodule

`default_nettype wire

//--- rtl/partialProductTree.sv
`timescale 1ns/1ps
`default_nettype none

module partialProductTree import approxMulPkg::*;
(
    input operandT opA,
    input operandT opB,
    output rowT p5,
    output rowT p6,
    output vecT v1,
    output vecT v2
);

    operandT pp [OperandWidth];
    logic [OperandWidth:0] row [4];
    vecT pairP;
    vecT pairQ;

    always_comb
    begin
        for (int i = 0; i < OperandWidth; i++)
            pp[i] = opA & {OperandWidth{opB[i]}};
    end

    always_comb
    begin
        v1 = '0;
        v2 = '0;

        // First level pairs neighbouring partial products, one column apart.
        for (int i = 0; i < 4; i++)
        begin
            icacPair(vecT'(pp[2*i]), vecT'(pp[2*i+1]), OperandWidth, 1, pairP, pairQ);
            row[i] = pairP[OperandWidth:0];
            v1 = v1 | (pairQ << (2 * i));
        end

        // Second level, rows now two columns apart.
        icacPair(vecT'(row[0]), vecT'(row[1]), OperandWidth + 1, 2, pairP, pairQ);
        p5 = pairP[OperandWidth+2:0];
        v2 = v2 | pairQ;

        icacPair(vecT'(row[2]), vecT'(row[3]), OperandWidth + 1, 2, pairP, pairQ);
        p6 = pairP[OperandWidth+2:0];
        v2 = v2 | (pairQ << 4);
    end

endmodule

`default_nettype wire

//--- rtl/axiLiteIf.sv
`timescale 1ns/1ps
`default_nettype none

interface axiLiteIf import approxMulPkg::*; ();

    logic [AddrWidth-1:0] awaddr;
    logic awvalid;
    logic awready;
    wordT wdata;
    logic wvalid;
    logic wready;
    axiRespE bresp;
    logic bvalid;
    logic bready;
    logic [AddrWidth-1:0] araddr;
    logic arvalid;
    logic arready;
    wordT rdata;
    axiRespE rresp;
    logic rvalid;
    logic rready;

    modport master (
        output awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
        input awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport slave (
        input awaddr, awvalid, wdata, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

`default_nettype wire

//--- rtl/approxMulPkg.sv
`default_nettype none

package approxMulPkg;

    localparam int OperandWidth = 8;
    localparam int ProductWidth = 16;
    localparam int ErrCtrlWidth = 7;
    localparam int AddrWidth = 4;
    localparam int DataWidth = 32;
    localparam int VecWidth = 2 * OperandWidth - 1;  // Column span of the compressor tree.

    typedef logic [OperandWidth-1:0] operandT;
    typedef logic [ProductWidth-1:0] productT;
    typedef logic [ErrCtrlWidth-1:0] errCtrlT;
    typedef logic [DataWidth-1:0] wordT;
    typedef logic [VecWidth-1:0] vecT;
    typedef logic [OperandWidth+2:0] rowT;  // Rows left after the second pairing level.

    typedef enum logic [1:0] {respOkay = 2'b00, respSlvErr = 2'b10} axiRespE;

    typedef enum logic [AddrWidth-1:0] {
        regErrCtrl = 4'h0,
        regOperands = 4'h4,
        regResult = 4'h8,
        regStatus = 4'hC
    } regAddrE;

    typedef enum logic {wrIdle, wrResp} wrStateE;
    typedef enum logic {rdIdle, rdData} rdStateE;

    // Incomplete carry-and-compress pairing. d2 is shifted left before it meets d1.
    function automatic void icacPair(input vecT d1, input vecT d2, input int width,
                                     input int shift, output vecT p, output vecT q);
        vecT shifted;
        shifted = d2 << shift;
        p = '0;
        q = '0;
        for (int i = 0; i < VecWidth; i++)
        begin
            if (i < shift)
                p[i] = d1[i];
            else if (i < width)
            begin
                p[i] = d1[i] | shifted[i];
                q[i] = d1[i] & shifted[i];  // Lost carry, kept as a residue.
            end
            else
                p[i] = shifted[i];
        end
    endfunction

endpackage

`default_nettype wire
